// ==== common/cpu_link_pkg.sv ====
// Shared word type, opcodes, instruction layout and pin frame constants for the CPU and its link
`default_nettype none

package cpu_link_pkg;

  // Data path and address word
  localparam int WORD_W = 32;
  typedef logic [WORD_W-1:0] word_t;

  // Pin frame layout
  localparam int WORD_BYTES  = 4;  // Bytes per word and per half frame
  localparam int FRAME_BEATS = 8;  // Address/data out beats, then read beats

  // Instruction word layout
  localparam int OPCODE_W   = 4;
  localparam int OPCODE_LSB = 28;  // Opcode in bits 31..28
  localparam int OPERAND_W  = 28;  // Word address operand in bits 27..0

  // Link address bit that marks a write frame
  localparam int WRITE_BIT = 31;

  // Unlisted encodings halt as well
  typedef enum logic [OPCODE_W-1:0] {
    op_load  = 4'h0,  // acc = mem[operand]
    op_store = 4'h1,  // mem[operand] = acc
    op_add   = 4'h2,  // acc = acc + mem[operand]
    op_sub   = 4'h3,  // acc = acc - mem[operand]
    op_jmp   = 4'h4,  // pc = operand
    op_jz    = 4'h5,  // pc = operand when acc is zero
    op_halt  = 4'h6   // Stop issuing requests
  } opcode_t;

endpackage

`default_nettype wire

// ==== hw/cpu/cpu_core.sv ====
// Accumulator CPU core, runs fetch and execute as single word requests to the byte link
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
  parameter cpu_link_pkg::word_t RESET_PC = '0  // Word address of the first fetch
) (
  input  logic                clk,
  input  logic                rst_n,
  output logic                req,        // One-cycle request strobe
  output cpu_link_pkg::word_t req_addr,
  output cpu_link_pkg::word_t req_wdata,
  input  logic                done,       // One-cycle completion strobe
  input  cpu_link_pkg::word_t rdata,
  output logic                halted
);

  typedef enum logic [2:0] {
    fetch_req,
    fetch_wait,
    decode,
    exec_req,
    exec_wait,
    halted_st
  } state_t;

  state_t                                state;
  logic [cpu_link_pkg::OPERAND_W-1:0]    pc;       // Word address of next instruction
  cpu_link_pkg::word_t                   acc;
  cpu_link_pkg::word_t                   ir;       // Current instruction
  cpu_link_pkg::opcode_t                 opcode;
  logic [cpu_link_pkg::OPERAND_W-1:0]    operand;
  logic [cpu_link_pkg::OPERAND_W-1:0]    pc_next;

  // Instruction fields
  assign opcode  = cpu_link_pkg::opcode_t'(
                     ir[cpu_link_pkg::OPCODE_LSB +: cpu_link_pkg::OPCODE_W]);
  assign operand = ir[cpu_link_pkg::OPERAND_W-1:0];
  assign pc_next = pc + 1'b1;

  // Control state and architectural registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= fetch_req;
      pc    <= RESET_PC[cpu_link_pkg::OPERAND_W-1:0];
      acc   <= '0;
    end else begin
      case (state)
        fetch_req: begin
          state <= fetch_wait;  // Link took the fetch this cycle
        end
        fetch_wait: begin
          if (done) begin
            state <= decode;
          end
        end
        decode: begin
          case (opcode)
            cpu_link_pkg::op_load,
            cpu_link_pkg::op_store,
            cpu_link_pkg::op_add,
            cpu_link_pkg::op_sub: begin
              pc    <= pc_next;
              state <= exec_req;  // Needs a second frame for the operand
            end
            cpu_link_pkg::op_jmp: begin
              pc    <= operand;
              state <= fetch_req;
            end
            cpu_link_pkg::op_jz: begin
              pc    <= (acc == '0) ? operand : pc_next;
              state <= fetch_req;
            end
            default: begin
              state <= halted_st;  // op_halt and unused encodings
            end
          endcase
        end
        exec_req: begin
          state <= exec_wait;
        end
        exec_wait: begin
          if (done) begin
            case (opcode)
              cpu_link_pkg::op_load: acc <= rdata;
              cpu_link_pkg::op_add:  acc <= acc + rdata;  // Wraps at 32 bits
              cpu_link_pkg::op_sub:  acc <= acc - rdata;
              default: ;                                  // Store leaves acc alone
            endcase
            state <= fetch_req;
          end
        end
        default: begin
          state <= halted_st;  // Stays here until reset
        end
      endcase
    end
  end

  // Instruction register loads on the fetch completion
  always_ff @(posedge clk) begin
    if (state == fetch_wait && done) begin
      ir <= rdata;
    end
  end

  // Link address, fetches use the pc and operand frames the operand
  always_comb begin
    req_addr = '0;
    if (state == exec_req) begin
      req_addr[cpu_link_pkg::OPERAND_W-1:0] = operand;
      req_addr[cpu_link_pkg::WRITE_BIT]     = (opcode == cpu_link_pkg::op_store);
    end else begin
      req_addr[cpu_link_pkg::OPERAND_W-1:0] = pc;
    end
  end

  assign req       = (state == fetch_req) || (state == exec_req);
  assign req_wdata = acc;  // Only a store frame writes it
  assign halted    = (state == halted_st);

  // Request states are never adjacent, so the link sees isolated pulses
  req_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) req |=> !req
  );

  // Once halted the core stays halted and silent
  halt_is_final: assert property (
    @(posedge clk) disable iff (!rst_n) halted |=> (halted && !req)
  );

endmodule

`default_nettype wire

// ==== hw/byte_link/byte_link.sv ====
// Byte-wide memory link that sends one word request as an eight beat pin frame and returns the read word
`timescale 1ns/1ps
`default_nettype none

module byte_link (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req,
  input  cpu_link_pkg::word_t req_addr,
  input  cpu_link_pkg::word_t req_wdata,
  output logic                done,
  output cpu_link_pkg::word_t rdata,
  output logic [7:0]          uo_out,
  output logic [7:0]          uio_out,
  output logic [7:0]          uio_oe,
  input  logic [7:0]          uio_in
);

  localparam int BEAT_W = $clog2(cpu_link_pkg::FRAME_BEATS + 1);
  localparam int IDX_W  = $clog2(cpu_link_pkg::WORD_BYTES);

  logic [BEAT_W-1:0]   beat;      // 0 is idle and 1..8 are frame beats
  logic [IDX_W-1:0]    byte_idx;  // Byte lane during the out beats
  logic                idle;
  logic                out_phase;
  logic                in_phase;
  cpu_link_pkg::word_t addr_q;
  cpu_link_pkg::word_t wdata_q;

  assign idle      = (beat == '0);
  assign out_phase = !idle && (beat <= BEAT_W'(cpu_link_pkg::WORD_BYTES));
  assign in_phase  = (beat > BEAT_W'(cpu_link_pkg::WORD_BYTES));
  assign byte_idx  = beat[IDX_W-1:0] - 1'b1;  // Beats 1..4 map to bytes 0..3

  // Beat counter and completion strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (idle) begin
        if (req) begin
          beat <= BEAT_W'(1);
        end
      end else if (beat == BEAT_W'(cpu_link_pkg::FRAME_BEATS)) begin
        beat <= '0;
        done <= 1'b1;  // Done cycle is already idle
      end else begin
        beat <= beat + 1'b1;
      end
    end
  end

  // Request capture and read assembly
  always_ff @(posedge clk) begin
    if (idle && req) begin
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
    if (in_phase) begin
      rdata <= {uio_in, rdata[cpu_link_pkg::WORD_W-1:8]};  // LSB byte arrives first
    end
  end

  // Pins driven only in the out beats and turned around for the rest of the frame
  assign uo_out  = out_phase ? addr_q[8*byte_idx +: 8]  : 8'h00;
  assign uio_out = out_phase ? wdata_q[8*byte_idx +: 8] : 8'h00;
  assign uio_oe  = {8{out_phase}};

  // Core must wait for done before the next request
  req_only_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) req |-> idle
  );

  // Bidirectional pins switch as one group and turn outward only for an accepted request
  oe_all_or_none: assert property (
    @(posedge clk) disable iff (!rst_n)
      (uio_oe == 8'h00) || ((uio_oe == 8'hFF) && $past((idle && req) || out_phase))
  );

endmodule

`default_nettype wire

// ==== hw/cpu_handler_top.sv ====
// Pin-level top, joins the CPU core to the byte link and exposes the eight-bit memory pins
`timescale 1ns/1ps
`default_nettype none

module cpu_handler_top #(
  parameter cpu_link_pkg::word_t RESET_PC = '0
) (
  input  logic [7:0] ui_in,    // Unused
  output logic [7:0] uo_out,   // Address bytes
  input  logic [7:0] uio_in,   // Read data bytes
  output logic [7:0] uio_out,  // Write data bytes
  output logic [7:0] uio_oe,
  input  logic       ena,      // Unused
  input  logic       clk,
  input  logic       rst_n,
  output logic       halted
);

  logic                req;
  cpu_link_pkg::word_t req_addr;
  cpu_link_pkg::word_t req_wdata;
  logic                done;
  cpu_link_pkg::word_t rdata;

  cpu_core #(
    .RESET_PC (RESET_PC)
  ) cpu_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .done      (done),
    .rdata     (rdata),
    .halted    (halted)
  );

  byte_link byte_link_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .done      (done),
    .rdata     (rdata),
    .uo_out    (uo_out),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe),
    .uio_in    (uio_in)
  );

  // Pins kept for the standard frame
  wire unused_pins = &{ui_in, ena, 1'b0};

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Testbench clock and active-low reset source, a rising reset_req starts another reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
) (
  input  logic reset_req,
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  always begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #5 rst_n = 1'b1;  // Released just after an edge
    @(posedge reset_req);
  end

endmodule

`default_nettype wire

// ==== test/tb_byte_memory.sv ====
// Pin-side word memory for the testbench, decodes eight beat frames and answers reads and writes
`timescale 1ns/1ps
`default_nettype none

module tb_byte_memory (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] uo_out,
  input  logic [7:0] uio_out,
  input  logic [7:0] uio_oe,
  output logic [7:0] uio_in
);

  cpu_link_pkg::word_t mem [0:63];    // Contents seen by the DUT
  cpu_link_pkg::word_t image [0:63];  // Copied into mem while reset is held
  cpu_link_pkg::word_t addr_word;
  cpu_link_pkg::word_t data_word;
  cpu_link_pkg::word_t read_word;
  cpu_link_pkg::word_t first_addr;
  cpu_link_pkg::word_t last_write_addr;
  int unsigned         beat;            // 0 outside a frame, then 1..8
  int unsigned         frame_count;
  int unsigned         write_count;
  int unsigned         errors;          // Kept across resets

  initial begin
    uio_in = 8'h00;
    beat   = 0;
    errors = 0;
  end

  task automatic check_pin(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s expected %h got %h in beat %0d", $time, name, exp, got, beat);
    end
  endtask

  // Acts a little after each edge, when the pins of the new beat have settled
  always @(posedge clk) begin
    #2;
    uio_in = 8'h00;
    if (!rst_n) begin
      beat        = 0;
      frame_count = 0;
      write_count = 0;
      first_addr  = '0;
      for (int i = 0; i < 64; i++) begin
        mem[i] = image[i];
      end
    end else if (beat == 0 && uio_oe !== 8'h00) begin
      beat = 1;  // Rising uio_oe opens a frame
      frame_count++;
      check_pin("uio_oe", uio_oe, 8'hff);
      addr_word[7:0] = uo_out;
      data_word[7:0] = uio_out;
    end else if (beat == 0) begin
      check_pin("uo_out", uo_out, 8'h00);
      check_pin("uio_out", uio_out, 8'h00);
    end else begin
      beat++;
      if (beat <= cpu_link_pkg::WORD_BYTES) begin
        check_pin("uio_oe", uio_oe, 8'hff);
        addr_word[8*(beat-1) +: 8] = uo_out;
        data_word[8*(beat-1) +: 8] = uio_out;
        if (beat == cpu_link_pkg::WORD_BYTES) begin
          if (frame_count == 1) first_addr = addr_word;
          if (addr_word[30:28] !== 3'b000) begin
            errors++;
            $display("frame address %h has bits 30 to 28 set at %0t ns", addr_word, $time);
          end
          if (addr_word[cpu_link_pkg::WRITE_BIT]) begin
            mem[addr_word[5:0]] = data_word;
            write_count++;
            last_write_addr = addr_word;
          end
          read_word = mem[addr_word[5:0]];
        end
      end else begin
        check_pin("uio_oe", uio_oe, 8'h00);  // Turned around for the read bytes
        check_pin("uio_out", uio_out, 8'h00);
        uio_in = read_word[8*(beat-5) +: 8];
        if (beat == cpu_link_pkg::FRAME_BEATS) beat = 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/cpu_handler_tb.sv ====
// Directed tests of the accumulator CPU through its byte-wide memory pins, run as the sim top
`timescale 1ns/1ps
`default_nettype none

module cpu_handler_tb;

  localparam int HALT_TIMEOUT = 2000;

  logic       clk;
  logic       rst_n;
  logic       reset_req = 1'b0;
  logic [7:0] ui_in;
  logic [7:0] uo_out;
  logic [7:0] uio_in;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;
  logic       ena;
  logic       halted;
  int         checks;
  int         fails;
  int         test_base;  // Failures seen before the running test

  tb_clock_gen clock_gen_inst (.reset_req(reset_req), .clk(clk), .rst_n(rst_n));

  tb_byte_memory mem_model (
    .clk(clk), .rst_n(rst_n), .uo_out(uo_out), .uio_out(uio_out), .uio_oe(uio_oe),
    .uio_in(uio_in)
  );

  cpu_handler_top #(.RESET_PC(32'd16)) cpu_handler_top_inst (
    .ui_in(ui_in), .uo_out(uo_out), .uio_in(uio_in), .uio_out(uio_out), .uio_oe(uio_oe),
    .ena(ena), .clk(clk), .rst_n(rst_n), .halted(halted)
  );

  function automatic cpu_link_pkg::word_t encode(cpu_link_pkg::opcode_t op, int unsigned addr);
    return {op, addr[cpu_link_pkg::OPERAND_W-1:0]};
  endfunction

  function automatic cpu_link_pkg::word_t fill_value(int i);
    return 32'hf0a5_0000 | cpu_link_pkg::word_t'(i);  // Opcode f halts a stray fetch
  endfunction

  task automatic check_word(string name, cpu_link_pkg::word_t got, cpu_link_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      fails++;
      $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      fails++;
      $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic report_problem(string msg);
    fails++;
    $display("at %0t ns: %s", $time, msg);
  endtask

  task automatic sample();
    @(posedge clk);
    #10;  // Between the input drive point and the next edge
  endtask

  task automatic clear_image();
    for (int i = 0; i < 64; i++) begin
      mem_model.image[i] = fill_value(i);
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 40) begin
      sample();
      n++;
    end
    if (rst_n !== 1'b1) report_problem("reset was never released");
  endtask

  // Starts a reset, checks idle pins and leaves the image blank for the program
  task automatic hold_reset();
    int n;
    @(posedge clk);
    #5;
    reset_req = 1'b1;
    n = 0;
    while (rst_n === 1'b1 && n < 4) begin
      sample();
      n++;
    end
    reset_req = 1'b0;
    if (rst_n === 1'b1) report_problem("reset could not be asserted");
    check_byte("uo_out", uo_out, 8'h00);
    check_byte("uio_out", uio_out, 8'h00);
    check_byte("uio_oe", uio_oe, 8'h00);
    clear_image();
  endtask

  task automatic run_to_halt();
    int n;
    wait_reset_release();
    n = 0;
    while (halted !== 1'b1 && n < HALT_TIMEOUT) begin
      sample();
      n++;
    end
    if (halted !== 1'b1) report_problem("core did not halt within 2000 cycles");
  endtask

  task automatic start_test();
    test_base = fails + mem_model.errors;
  endtask

  task automatic end_test(string name);
    if (fails + mem_model.errors == test_base) $display("test %s: ok", name);
    else $display("test %s: %0d problems", name, fails + mem_model.errors - test_base);
  endtask

  task automatic reset_and_first_frame_test();
    start_test();
    hold_reset();
    mem_model.image[16] = encode(cpu_link_pkg::op_halt, 0);
    run_to_halt();
    check_word("first frame address", mem_model.first_addr, 32'd16);
    check_word("frame count", cpu_link_pkg::word_t'(mem_model.frame_count), 32'd1);
    end_test("reset and first frame");
  endtask

  task automatic load_add_store_test();
    cpu_link_pkg::word_t a;
    cpu_link_pkg::word_t b;
    cpu_link_pkg::word_t waddr;
    a = 32'hffff_fff0;
    b = 32'h0000_0025;  // Sum wraps past 2**32
    waddr = 32'd50;
    waddr[cpu_link_pkg::WRITE_BIT] = 1'b1;
    start_test();
    hold_reset();
    mem_model.image[16] = encode(cpu_link_pkg::op_load, 48);
    mem_model.image[17] = encode(cpu_link_pkg::op_add, 49);
    mem_model.image[18] = encode(cpu_link_pkg::op_store, 50);
    mem_model.image[19] = encode(cpu_link_pkg::op_halt, 0);
    mem_model.image[48] = a;
    mem_model.image[49] = b;
    run_to_halt();
    check_word("mem[50]", mem_model.mem[50], a + b);
    check_word("store frame address", mem_model.last_write_addr, waddr);
    check_word("write count", cpu_link_pkg::word_t'(mem_model.write_count), 32'd1);
    end_test("load add store");
  endtask

  task automatic sub_jz_run(cpu_link_pkg::word_t x, cpu_link_pkg::word_t y);
    cpu_link_pkg::word_t marker;
    marker = 32'hc0de_0001;
    hold_reset();
    mem_model.image[16] = encode(cpu_link_pkg::op_load, 48);
    mem_model.image[17] = encode(cpu_link_pkg::op_sub, 49);
    mem_model.image[18] = encode(cpu_link_pkg::op_jz, 21);
    mem_model.image[19] = encode(cpu_link_pkg::op_store, 52);  // Fall-through path
    mem_model.image[20] = encode(cpu_link_pkg::op_halt, 0);
    mem_model.image[21] = encode(cpu_link_pkg::op_load, 51);   // Jump target
    mem_model.image[22] = encode(cpu_link_pkg::op_store, 53);
    mem_model.image[23] = encode(cpu_link_pkg::op_halt, 0);
    mem_model.image[48] = x;
    mem_model.image[49] = y;
    mem_model.image[51] = marker;
    run_to_halt();
    if (x == y) begin
      check_word("mem[53]", mem_model.mem[53], marker);
      check_word("mem[52]", mem_model.mem[52], fill_value(52));
    end else begin
      check_word("mem[53]", mem_model.mem[53], fill_value(53));
      check_word("mem[52]", mem_model.mem[52], x - y);
    end
  endtask

  task automatic sub_jz_test();
    start_test();
    sub_jz_run(32'h1234_5678, 32'h1234_5678);
    sub_jz_run(32'h0000_0003, 32'h0000_0008);
    end_test("sub and jz");
  endtask

  task automatic jmp_halt_test();
    logic [7:0] oe_seen;
    start_test();
    hold_reset();
    mem_model.image[16] = encode(cpu_link_pkg::op_load, 48);
    mem_model.image[17] = encode(cpu_link_pkg::op_jmp, 19);
    mem_model.image[18] = encode(cpu_link_pkg::op_store, 54);  // Skipped
    mem_model.image[19] = encode(cpu_link_pkg::op_store, 55);
    mem_model.image[20] = encode(cpu_link_pkg::op_halt, 0);
    mem_model.image[48] = 32'h0bad_cafe;
    run_to_halt();
    oe_seen = 8'h00;
    for (int n = 0; n < 200; n++) begin
      sample();
      oe_seen |= uio_oe;
    end
    check_byte("uio_oe after halt", oe_seen, 8'h00);
    check_word("mem[54]", mem_model.mem[54], fill_value(54));
    check_word("mem[55]", mem_model.mem[55], 32'h0bad_cafe);
    check_word("frame count", cpu_link_pkg::word_t'(mem_model.frame_count), 32'd6);
    end_test("jmp and halt");
  endtask

  task automatic random_arith_test();
    cpu_link_pkg::word_t a;
    cpu_link_pkg::word_t b;
    start_test();
    for (int k = 0; k < 10; k++) begin
      a = $urandom();
      b = $urandom();
      hold_reset();
      mem_model.image[16] = encode(cpu_link_pkg::op_load, 48);
      mem_model.image[17] = encode(cpu_link_pkg::op_add, 49);
      mem_model.image[18] = encode(cpu_link_pkg::op_store, 50);
      mem_model.image[19] = encode(cpu_link_pkg::op_load, 48);
      mem_model.image[20] = encode(cpu_link_pkg::op_sub, 49);
      mem_model.image[21] = encode(cpu_link_pkg::op_store, 51);
      mem_model.image[22] = encode(cpu_link_pkg::op_halt, 0);
      mem_model.image[48] = a;
      mem_model.image[49] = b;
      run_to_halt();
      check_word("sum in mem[50]", mem_model.mem[50], a + b);
      check_word("difference in mem[51]", mem_model.mem[51], a - b);
    end
    end_test("random arithmetic");
  endtask

  initial begin
    ui_in     = 8'h00;
    ena       = 1'b1;
    checks    = 0;
    fails     = 0;
    test_base = 0;
    void'($urandom(32'hccc2_969b));
    clear_image();
    wait_reset_release();
    reset_and_first_frame_test();
    load_add_store_test();
    sub_jz_test();
    jmp_halt_test();
    random_arith_test();
    fails = fails + mem_model.errors;
    $display("checks %0d, failures %0d", checks, fails);
    if (fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/cpu_link_pkg.sv
hw/cpu/cpu_core.sv
hw/byte_link/byte_link.sv
hw/cpu_handler_top.sv
test/tb_clock_gen.sv
test/tb_byte_memory.sv
test/cpu_handler_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpu_handler_tb \
  -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_bin)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
exit 1
